/* tb.f */
+incdir+testbench
logic/madam_bus_pkg.sv
logic/madam_math_pkg.sv
logic/pcsc_capture.sv
logic/matrix_engine.sv
logic/madam_regs.sv
logic/madam_top.sv
testbench/tb_madam.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_madam -f tb.f
	./obj_dir/Vtb_madam | tee /dev/stderr | grep -x "All checks passed" > /dev/null

clean:
	rm -rf obj_dir

/* testbench/tb_madam_tasks.svh */
// MADAM testbench helpers

// one APB transfer, waits out a stalled access cycle.
task automatic apb_access(input logic wr, input reg_addr_t addr, input word_t wdata,
		output word_t rdata);
	int waits;
	@(negedge clk_25m);
	apb_req.psel    = 1'b1; // setup cycle.
	apb_req.penable = 1'b0;
	apb_req.pwrite  = wr;
	apb_req.paddr   = addr;
	apb_req.pwdata  = wdata;
	@(negedge clk_25m);
	apb_req.penable = 1'b1; // first access cycle.
	#1;
	waits = 0;
	while (!apb_rsp.pready && waits < 100) begin
		@(negedge clk_25m);
		#1;
		waits++;
	end
	if (!apb_rsp.pready) begin
		$display("timeout: pready stayed low for 100 cycles at address %h", addr);
		errors++;
	end
	rdata = apb_rsp.prdata; // valid while pready is high.
	@(negedge clk_25m);
	apb_req.psel    = 1'b0; // transfer ended on the last rising edge.
	apb_req.penable = 1'b0;
endtask

task automatic apb_write(input reg_addr_t addr, input word_t data);
	word_t ignored;
	apb_access(1'b1, addr, data, ignored);
endtask

task automatic apb_read(input reg_addr_t addr, output word_t data);
	apb_access(1'b0, addr, '0, data);
endtask

// 32-bit xorshift step.
function automatic word_t xorshift32(input word_t x);
	word_t s;
	s = x;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

function automatic word_t next_rand();
	rng_state = xorshift32(rng_state);
	return rng_state;
endfunction

// operand in -0x80000 .. 0x7ffff.
function automatic fix16_t rand_operand();
	word_t r;
	r = next_rand();
	return fix16_t'({12'd0, r[19:0]}) - fix16_t'(32'h0008_0000);
endfunction

// reference row result, sum of products then floor shift by 16.
function automatic fix16_t mat_row_model(input int row, input int dim);
	acc_t sum;
	sum = '0;
	for (int c = 0; c < dim; c++) begin
		sum += acc_t'(m_tb[row * 4 + c]) * acc_t'(v_tb[c]);
	end
	return fix16_t'(sum >>> 16);
endfunction

// fresh random matrix and vector, mirrored in m_tb and v_tb.
task automatic load_operands();
	for (int i = 0; i < 16; i++) begin
		m_tb[i] = rand_operand();
		apb_write(ADDR_M_BASE + reg_addr_t'(4 * i), m_tb[i]);
	end
	for (int i = 0; i < 4; i++) begin
		v_tb[i] = rand_operand();
		apb_write(ADDR_V_BASE + reg_addr_t'(4 * i), v_tb[i]);
	end
endtask

// low, sync high, then flag bits 1 to 7 one per cycle.
task automatic send_pcsc_frame(input logic [6:0] bits);
	@(negedge clk_25m);
	pcsc = 1'b0;
	@(negedge clk_25m);
	pcsc = 1'b1; // rising edge seen on the next clock.
	for (int k = 0; k < 7; k++) begin
		@(negedge clk_25m);
		pcsc = bits[k];
	end
	@(negedge clk_25m);
	pcsc = 1'b0;
endtask

/* testbench/tb_madam.sv */
// MADAM testbench
`timescale 1ns/1ps

module tb_madam;
	import madam_bus_pkg::*;
	import madam_math_pkg::*;

	logic     clk_25m;
	logic     reset_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     pcsc;
	word_t    rng_state;   // xorshift state.
	fix16_t   m_tb [16];   // matrix as written to the DUT.
	fix16_t   v_tb [4];
	fix16_t   rez3_mul4;   // rez3 of the 4x4 command.
	int       checks;
	int       errors;
	int       test_errors; // errors before the current test.

	madam_top #(
		.HCOUNT_WIDTH(12)
	) u_madam_top (
		.clk_25m (clk_25m),
		.reset_n (reset_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.pcsc    (pcsc)
	);

	`include "tb_madam_tasks.svh"

	initial begin
		clk_25m = 1'b0;
		forever #20 clk_25m = ~clk_25m; // 40 ns period.
	end

	a_idle_ready: assert property (@(posedge clk_25m) disable iff (!reset_n)
		!apb_req.psel |-> apb_rsp.pready) else begin
		$display("pready was low with no transfer on the bus");
		errors++;
	end

	// reads are never held off.
	a_read_ready: assert property (@(posedge clk_25m) disable iff (!reset_n)
		(apb_req.psel && apb_req.penable && !apb_req.pwrite) |-> apb_rsp.pready) else begin
		$display("a read access was stalled");
		errors++;
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			$display("error: %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input int num, input string what);
		$display("test %0d %s: %0d errors", num, what, errors - test_errors);
		test_errors = errors;
	endtask

	initial begin
		word_t      rd;
		word_t      h_first;
		word_t      val;
		logic [6:0] bits;
		apb_req     = '0;
		pcsc        = 1'b0;
		reset_n     = 1'b0;
		rng_state   = 32'd96;
		checks      = 0;
		errors      = 0;
		test_errors = 0;
		repeat (16) @(posedge clk_25m); // sixteen clock edges in reset.
		@(negedge clk_25m);
		reset_n = 1'b1;

		apb_read(ADDR_MSYSBITS, rd);
		check_word("msysbits", rd, 32'h0000_0029);
		apb_read(ADDR_MCTL, rd);
		check_word("mctl", rd, 32'h0);
		apb_read(16'h0100, rd); // nothing mapped here.
		check_word("unmapped", rd, 32'hBADA_CCE5);
		for (int i = 0; i < 4; i++) begin
			apb_read(ADDR_REZ_BASE + reg_addr_t'(4 * i), rd);
			check_word($sformatf("rez%0d", i), rd, 32'h0);
		end
		finish_test(1, "after reset");

		val = next_rand();
		apb_write(ADDR_MCTL, val);
		apb_read(ADDR_MCTL, rd);
		check_word("mctl", rd, val);
		load_operands();
		for (int i = 0; i < 16; i++) begin
			apb_read(ADDR_M_BASE + reg_addr_t'(4 * i), rd);
			check_word($sformatf("m%0d", i), rd, m_tb[i]);
		end
		for (int i = 0; i < 4; i++) begin
			apb_read(ADDR_V_BASE + reg_addr_t'(4 * i), rd);
			check_word($sformatf("v%0d", i), rd, v_tb[i]);
		end
		finish_test(2, "read-back");

		load_operands();
		apb_write(ADDR_MCMD, 32'd1);
		for (int i = 0; i < 4; i++) begin // old bank, still zero.
			apb_read(ADDR_REZ_BASE + reg_addr_t'(4 * i), rd);
			check_word($sformatf("rez%0d", i), rd, 32'h0);
		end
		apb_write(ADDR_MCMD, 32'd0); // stalls until the engine is done.
		for (int i = 0; i < 4; i++) begin
			apb_read(ADDR_REZ_BASE + reg_addr_t'(4 * i), rd);
			check_word($sformatf("rez%0d", i), rd, mat_row_model(i, 4));
		end
		rez3_mul4 = mat_row_model(3, 4);
		finish_test(3, "4x4 multiply");

		load_operands();
		apb_write(ADDR_MCMD, 32'd2);
		apb_write(ADDR_MCMD, 32'd0);
		for (int i = 0; i < 3; i++) begin
			apb_read(ADDR_REZ_BASE + reg_addr_t'(4 * i), rd);
			check_word($sformatf("rez%0d", i), rd, mat_row_model(i, 3));
		end
		apb_read(ADDR_REZ_BASE + 16'h000C, rd);
		check_word("rez3", rd, rez3_mul4); // left over from the 4x4 command.
		finish_test(4, "3x3 multiply");

		val  = next_rand();
		bits = val[6:0];
		send_pcsc_frame(bits);
		apb_read(ADDR_VFLAGS, rd);
		check_word("vflags", rd, {24'd0, bits, 1'b0});
		send_pcsc_frame(7'b0101010); // bit 2 is a rising edge inside the capture.
		apb_read(ADDR_VFLAGS, rd);
		check_word("vflags", rd, {24'd0, 7'b0101010, 1'b0});
		finish_test(5, "video flags");

		apb_read(ADDR_HCOUNT, h_first);
		repeat (5) @(negedge clk_25m);
		apb_read(ADDR_HCOUNT, rd);
		checks++;
		assert (rd > h_first) else begin
			$display("error: hcount got %h after earlier %h", rd, h_first);
			errors++;
		end
		finish_test(6, "horizontal counter");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* logic/madam_top.sv */
// MADAM top level
`timescale 1ns/1ps

module madam_top #(
	parameter int HCOUNT_WIDTH = 12
) (
	input  logic                    clk_25m,
	input  logic                    reset_n,
	input  madam_bus_pkg::apb_req_t apb_req,
	output madam_bus_pkg::apb_rsp_t apb_rsp,
	input  logic                    pcsc
);
	import madam_math_pkg::*;

	video_flags_t            flags;
	logic [HCOUNT_WIDTH-1:0] hcount;   // counter as wide as the capture makes it.
	mat_operands_t           operands;
	mat_cmd_e                cmd;
	logic                    start;
	mat_result_t             rez;
	logic                    busy;

	pcsc_capture #(
		.HCOUNT_WIDTH(HCOUNT_WIDTH)
	) u_pcsc_capture (
		.clk_25m (clk_25m),
		.reset_n (reset_n),
		.pcsc    (pcsc),
		.flags   (flags),
		.hcount  (hcount)
	);

	matrix_engine u_matrix_engine (
		.clk_25m  (clk_25m),
		.reset_n  (reset_n),
		.operands (operands),
		.cmd      (cmd),
		.start    (start),
		.rez      (rez),
		.busy     (busy)
	);

	madam_regs u_madam_regs (
		.clk_25m  (clk_25m),
		.reset_n  (reset_n),
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.flags    (flags),
		.hcount   (hcount_t'(hcount)), // register is 12 bits whatever the counter width.
		.rez      (rez),
		.busy     (busy),
		.operands (operands),
		.cmd      (cmd),
		.start    (start)
	);

endmodule

/* logic/madam_regs.sv */
// MADAM APB register block
`timescale 1ns/1ps

module madam_regs (
	input  logic                          clk_25m,
	input  logic                          reset_n,
	input  madam_bus_pkg::apb_req_t       apb_req,
	output madam_bus_pkg::apb_rsp_t       apb_rsp,
	input  madam_math_pkg::video_flags_t  flags,
	input  madam_math_pkg::hcount_t       hcount,
	input  madam_math_pkg::mat_result_t   rez,
	input  logic                          busy,
	output madam_math_pkg::mat_operands_t operands,
	output madam_math_pkg::mat_cmd_e      cmd,
	output logic                          start
);
	import madam_bus_pkg::*;
	import madam_math_pkg::*;

	word_t mctl;    // dma enables, stored but not acted on.
	word_t rd_data;
	logic  access;  // second and later cycles of a transfer.
	logic  aligned;
	logic  is_msys, is_mctl, is_vflags, is_hcount, is_mcmd;
	logic  is_mat, is_vec, is_rez;
	logic  stall;
	logic  wr_en;

	// address decode, the matrix windows need word aligned offsets.
	assign aligned   = (apb_req.paddr[1:0] == 2'b00);
	assign is_msys   = (apb_req.paddr == ADDR_MSYSBITS);
	assign is_mctl   = (apb_req.paddr == ADDR_MCTL);
	assign is_vflags = (apb_req.paddr == ADDR_VFLAGS);
	assign is_hcount = (apb_req.paddr == ADDR_HCOUNT);
	assign is_mcmd   = (apb_req.paddr == ADDR_MCMD);
	assign is_mat    = aligned && (apb_req.paddr[15:6] == ADDR_M_BASE[15:6]);
	assign is_vec    = aligned && (apb_req.paddr[15:4] == ADDR_V_BASE[15:4]);
	assign is_rez    = aligned && (apb_req.paddr[15:4] == ADDR_REZ_BASE[15:4]);

	assign access = apb_req.psel && apb_req.penable;

	// engine owns the operands and the command while it runs.
	assign stall = access && apb_req.pwrite && busy && (is_mcmd || is_mat || is_vec);
	assign wr_en = access && apb_req.pwrite && !stall;

	always_ff @(posedge clk_25m) begin
		if (!reset_n) begin
			mctl     <= '0;
			operands <= '0;
			cmd      <= CMD_NOP;
			start    <= 1'b0;
		end else begin
			start <= wr_en && is_mcmd; // single cycle, engine is idle here.
			if (wr_en) begin
				if (is_mctl) begin
					mctl <= apb_req.pwdata;
				end
				if (is_mat) begin
					operands.m[apb_req.paddr[5:2]] <= apb_req.pwdata;
				end
				if (is_vec) begin
					operands.v[apb_req.paddr[3:2]] <= apb_req.pwdata;
				end
				if (is_mcmd) begin
					case (apb_req.pwdata)
						32'd1:   cmd <= CMD_MUL4;
						32'd2:   cmd <= CMD_MUL3;
						default: cmd <= CMD_NOP; // unknown codes only latch results.
					endcase
				end
			end
		end
	end

	// read mux.
	always_comb begin
		rd_data = UNMAPPED_VALUE;
		if (is_msys) begin
			rd_data = MSYSBITS_VALUE;
		end else if (is_mctl) begin
			rd_data = mctl;
		end else if (is_vflags) begin
			rd_data = {24'd0, flags, 1'b0}; // bit 0 has no flag.
		end else if (is_hcount) begin
			rd_data = word_t'(hcount);
		end else if (is_mat) begin
			rd_data = operands.m[apb_req.paddr[5:2]];
		end else if (is_vec) begin
			rd_data = operands.v[apb_req.paddr[3:2]];
		end else if (is_rez) begin
			rd_data = rez.r[apb_req.paddr[3:2]];
		end
	end

	assign apb_rsp = '{prdata: rd_data, pready: !stall};

	a_idle_ready: assert property (@(posedge clk_25m) disable iff (!reset_n)
		!apb_req.psel |-> apb_rsp.pready);

endmodule

/* logic/matrix_engine.sv */
// matrix multiply engine
`timescale 1ns/1ps

module matrix_engine (
	input  logic                          clk_25m,
	input  logic                          reset_n,
	input  madam_math_pkg::mat_operands_t operands,
	input  madam_math_pkg::mat_cmd_e      cmd,
	input  logic                          start,
	output madam_math_pkg::mat_result_t   rez,
	output logic                          busy
);
	import madam_math_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		MAC,
		STORE
	} state_e;

	state_e      state_q;
	logic [1:0]  row_q;
	logic [1:0]  col_q;
	logic [1:0]  last_q;     // highest row and column index of the command.
	mat_result_t temp_q;     // results of the command in progress.
	acc_t        acc_q;      // running sum of the current row.
	acc_t        prod;
	fix16_t      mat_a;
	fix16_t      mat_b;
	fix16_t      row_result;

	assign busy = (state_q != IDLE);

	// one shared multiplier, operands picked by the counters.
	assign mat_a = operands.m[{row_q, col_q}];
	assign mat_b = operands.v[col_q];
	assign prod  = mat_a * mat_b; // sign extended to 64 bits before the multiply.

	// drop the 16 fraction bits, floor toward minus infinity.
	assign row_result = fix16_t'(acc_q >>> 16);

	always_ff @(posedge clk_25m) begin
		if (!reset_n) begin
			state_q <= IDLE;
			row_q   <= 2'd0;
			col_q   <= 2'd0;
			last_q  <= 2'd0;
			temp_q  <= '0;
			rez     <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (start) begin
						rez   <= temp_q; // previous command becomes visible.
						row_q <= 2'd0;
						col_q <= 2'd0;
						if (cmd == CMD_MUL4) begin
							last_q  <= 2'd3;
							state_q <= MAC;
						end else if (cmd == CMD_MUL3) begin
							last_q  <= 2'd2;
							state_q <= MAC;
						end
					end
				end
				MAC: begin
					// acc holds the finished row before when a new row begins.
					if (col_q == 2'd0 && row_q != 2'd0) begin
						temp_q.r[row_q - 2'd1] <= row_result;
					end
					if (col_q == last_q) begin
						col_q <= 2'd0;
						if (row_q == last_q) begin
							state_q <= STORE;
						end else begin
							row_q <= row_q + 2'd1;
						end
					end else begin
						col_q <= col_q + 2'd1;
					end
				end
				STORE: begin
					temp_q.r[last_q] <= row_result; // last row, rez3 untouched for 3x3.
					state_q <= IDLE;
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// accumulator restarts on the first product of every row.
	always_ff @(posedge clk_25m) begin
		if (state_q == MAC) begin
			if (col_q == 2'd0) begin
				acc_q <= prod;
			end else begin
				acc_q <= acc_q + prod;
			end
		end
	end

	a_no_start_busy: assert property (@(posedge clk_25m) disable iff (!reset_n)
		start |-> !busy);

	a_col_in_range: assert property (@(posedge clk_25m) disable iff (!reset_n)
		(state_q == MAC) |-> (col_q <= last_q));

endmodule

/* logic/pcsc_capture.sv */
// pcsc video flag capture
`timescale 1ns/1ps

module pcsc_capture #(
	parameter int HCOUNT_WIDTH = 12
) (
	input  logic                         clk_25m,
	input  logic                         reset_n,
	input  logic                         pcsc,
	output madam_math_pkg::video_flags_t flags,
	output logic [HCOUNT_WIDTH-1:0]      hcount
);
	import madam_math_pkg::*;

	logic         pcsc_dly; // pcsc one edge back.
	logic [2:0]   bit_idx;  // 0 idle, 1 to 7 selects the next flag bit.
	logic         publish;  // last bit went in on the previous edge.
	logic         sync;
	video_flags_t shift_q;  // flags in flight.

	// rising edge of pcsc, ignored while a capture runs.
	assign sync = pcsc && !pcsc_dly && (bit_idx == 3'd0);

	always_ff @(posedge clk_25m) begin
		if (!reset_n) begin
			pcsc_dly <= 1'b0;
			bit_idx  <= 3'd0;
			publish  <= 1'b0;
			hcount   <= '0;
			flags    <= '0;
		end else begin
			pcsc_dly <= pcsc;
			publish  <= (bit_idx == 3'd7);
			if (sync) begin
				hcount  <= '0;   // line starts here.
				bit_idx <= 3'd1;
			end else begin
				hcount <= hcount + HCOUNT_WIDTH'(1); // free running, wraps.
			end
			if (bit_idx != 3'd0) begin
				bit_idx <= bit_idx + 3'd1; // 7 wraps back to idle.
			end
			if (publish) begin
				flags <= shift_q; // all seven bits complete.
			end
		end
	end

	// shift in from the top so bit 1 of pcsc ends up in vz.
	always_ff @(posedge clk_25m) begin
		if (bit_idx != 3'd0) begin
			shift_q <= {pcsc, shift_q[6:1]};
		end
	end

	// an accepted sync restarts the line count.
	a_sync_clears_hcount: assert property (@(posedge clk_25m) disable iff (!reset_n)
		sync |=> (hcount == '0));

endmodule

/* logic/madam_math_pkg.sv */
// MADAM matrix and video types
package madam_math_pkg;

	typedef logic signed [31:0] fix16_t; // 16.16 fixed point.
	typedef logic signed [63:0] acc_t;   // full width sum of products.
	typedef logic [11:0] hcount_t;       // pixel clock counter.

	// matrix engine inputs, m index is row * 4 + column.
	typedef struct packed {
		fix16_t [15:0] m;
		fix16_t [3:0]  v;
	} mat_operands_t;

	// one bank of matrix results.
	typedef struct packed {
		fix16_t [3:0] r;
	} mat_result_t;

	typedef enum logic [1:0] {
		CMD_NOP  = 2'd0, // latch results only.
		CMD_MUL4 = 2'd1, // 4x4 matrix times 4-vector.
		CMD_MUL3 = 2'd2  // 3x3 matrix times 3-vector.
	} mat_cmd_e;

	// flag bits as sent on pcsc, vz arrives first and lands in the lsb.
	typedef struct packed {
		logic last_line;   // vcnt at last line.
		logic pal;         // pal when set, ntsc otherwise.
		logic virs;        // virs test pattern.
		logic forced_clut; // forced clut.
		logic field;       // field 0 or 1.
		logic v_odd;       // odd line.
		logic vz;          // vcnt is zero.
	} video_flags_t;

endpackage

/* logic/madam_bus_pkg.sv */
// MADAM register bus definitions
package madam_bus_pkg;

	typedef logic [15:0] reg_addr_t; // byte offset inside the MADAM window.
	typedef logic [31:0] word_t;     // cpu data word.

	// master side of an APB transfer.
	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		reg_addr_t paddr;
		word_t     pwdata;
	} apb_req_t;

	// slave side of an APB transfer.
	typedef struct packed {
		word_t prdata;
		logic  pready;
	} apb_rsp_t;

	// register offsets.
	localparam reg_addr_t ADDR_MSYSBITS = 16'h0004; // memory configuration, read only.
	localparam reg_addr_t ADDR_MCTL     = 16'h0008; // dma channel enables.
	localparam reg_addr_t ADDR_VFLAGS   = 16'h0010; // video flags from pcsc.
	localparam reg_addr_t ADDR_HCOUNT   = 16'h0014; // pixel clocks since the last sync.
	localparam reg_addr_t ADDR_M_BASE   = 16'h0600; // m00 to m33, row by row.
	localparam reg_addr_t ADDR_V_BASE   = 16'h0640; // v0 to v3.
	localparam reg_addr_t ADDR_REZ_BASE = 16'h0660; // rez0 to rez3.
	localparam reg_addr_t ADDR_MCMD     = 16'h07FC; // matrix engine command.

	// fixed read values.
	localparam word_t MSYSBITS_VALUE = 32'h0000_0029; // 2MB dram, 1MB vram.
	localparam word_t UNMAPPED_VALUE = 32'hBADA_CCE5;

endpackage
